/* rv_decode_pkg.sv */
package rv_decode_pkg;

   localparam int XLEN      = 32; // word width
   localparam int REG_IDX_W = 5;  // x0..x31

   // major opcode, instr[6:2]
   typedef enum logic [4:0] {
      OPC_LOAD    = 5'b00000,
      OPC_MISCMEM = 5'b00011,  // fence
      OPC_OPIMM   = 5'b00100,
      OPC_AUIPC   = 5'b00101,
      OPC_STORE   = 5'b01000,
      OPC_OP      = 5'b01100,
      OPC_LUI     = 5'b01101,
      OPC_BRANCH  = 5'b11000,
      OPC_JALR    = 5'b11001,
      OPC_JAL     = 5'b11011,
      OPC_SYSTEM  = 5'b11100   // ecall, ebreak, csr
   } opcode_e;

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
      ALU_OR, ALU_AND, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, ALU_DIV,
      ALU_DIVU, ALU_REM, ALU_REMU
   } alu_op_e;

   typedef enum logic       {S1_REGVAL1, S1_PC} alu_s1_sel_e;  // alu operand 1
   typedef enum logic [1:0] {S2_REGVAL2, S2_IMM} alu_s2_sel_e; // alu operand 2
   typedef enum logic [1:0] {RIN_ALU, RIN_IMM} reg_input_sel_e; // regfile write source

   typedef enum logic [2:0] {
      STG_FETCH, STG_LOAD, STG_STORE, STG_BRANCH, STG_SYSTEM, STG_TRAP, STG_DEAD
   } exec_stage_e;

   localparam logic [2:0] F3_BEQ  = 3'b000; // branch conditions
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   localparam logic [2:0] F3_ADD_SUB = 3'b000; // op and op-imm share these
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] FUNC_LW    = 3'b010; // word access, reported for all rvc

   localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub / sra
   localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // m extension

   localparam logic [1:0] C_Q0  = 2'b00;
   localparam logic [1:0] C_Q1  = 2'b01;
   localparam logic [1:0] C_Q2  = 2'b10;
   localparam logic [1:0] C_Q32 = 2'b11; // not compressed

   localparam logic [2:0] C0_F3_ADDI4SPN = 3'b000;
   localparam logic [2:0] C0_F3_LW       = 3'b010;
   localparam logic [2:0] C0_F3_SW       = 3'b110;
   localparam logic [2:0] C2_F3_SLLI     = 3'b000;
   localparam logic [2:0] C2_F3_LWSP     = 3'b010;
   localparam logic [2:0] C2_F3_JR       = 3'b100; // jr, mv, ebreak, jalr, add
   localparam logic [2:0] C2_F3_SWSP     = 3'b110;

   localparam logic [4:0] SP_REG = 5'd2; // x2 stack pointer
   localparam logic [4:0] RA_REG = 5'd1; // x1 link register

endpackage

/* rv32_decoder.sv */
`timescale 1ns/100ps
module rv32_decoder
   import rv_decode_pkg::*;
#(
   parameter bit P_EXT_M = 1'b1 // decode mul/div/rem
) (
   input  logic [XLEN-1:0]      i_instr,
   output logic [REG_IDX_W-1:0] o_rs1,
   output logic [REG_IDX_W-1:0] o_rs2,
   output logic [REG_IDX_W-1:0] o_rd,
   output logic [XLEN-1:0]      o_imm,
   output alu_op_e              o_alu_op,
   output alu_s1_sel_e          o_s1_sel,
   output alu_s2_sel_e          o_s2_sel,
   output logic                 o_wb_from_alu,
   output logic                 o_wb_from_imm,
   output logic                 o_next_pc_from_alu,
   output logic                 o_write_reg,
   output reg_input_sel_e       o_reg_input_sel,
   output logic [2:0]           o_funct3,
   output exec_stage_e          o_next_stage,
   output logic [5:0]           o_branch_mask
);
   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_m;
   logic       alt;

   assign opcode   = opcode_e'(i_instr[6:2]);
   assign funct3   = i_instr[14:12];
   assign funct7   = i_instr[31:25];
   assign is_m     = P_EXT_M && (funct7 == FUNCT7_MULDIV); // off -> base meaning
   assign alt      = (funct7 == FUNCT7_ALT);
   assign o_rs1    = i_instr[19:15]; // fixed fields, regfile read during decode
   assign o_rs2    = i_instr[24:20];
   assign o_rd     = i_instr[11:7];
   assign o_funct3 = funct3;

   function automatic alu_op_e base_op(input logic [2:0] f3, input logic sub, input logic sra);
      case (f3)
         F3_ADD_SUB: base_op = sub ? ALU_SUB : ALU_ADD;
         F3_SLL:     base_op = ALU_SLL;
         F3_SLT:     base_op = ALU_SLT;
         F3_SLTU:    base_op = ALU_SLTU;
         F3_XOR:     base_op = ALU_XOR;
         F3_SRL_SRA: base_op = sra ? ALU_SRA : ALU_SRL;
         F3_OR:      base_op = ALU_OR;
         default:    base_op = ALU_AND;
      endcase
   endfunction

   function automatic alu_op_e m_op(input logic [2:0] f3);
      case (f3)
         F3_ADD_SUB: m_op = ALU_MUL;
         F3_SLL:     m_op = ALU_MULH;
         F3_SLT:     m_op = ALU_MULHSU;
         F3_SLTU:    m_op = ALU_MULHU;
         F3_XOR:     m_op = ALU_DIV;
         F3_SRL_SRA: m_op = ALU_DIVU;
         F3_OR:      m_op = ALU_REM;
         default:    m_op = ALU_REMU;
      endcase
   endfunction

   always_comb begin
      case (opcode)
         OPC_STORE:          o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]}; // s
         OPC_BRANCH:         o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                                      i_instr[11:8], 1'b0}; // b
         OPC_LUI, OPC_AUIPC: o_imm = {i_instr[31:12], 12'b0}; // u
         OPC_JAL:            o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                                      i_instr[30:21], 1'b0}; // j
         default:            o_imm = {{20{i_instr[31]}}, i_instr[31:20]}; // i, junk for r
      endcase
   end

   always_comb begin
      o_alu_op           = ALU_ADD; // address / link add unless overridden
      o_s1_sel           = S1_REGVAL1;
      o_s2_sel           = S2_REGVAL2;
      o_wb_from_alu      = 1'b0;
      o_wb_from_imm      = 1'b0;
      o_next_pc_from_alu = 1'b0;
      o_write_reg        = 1'b0;
      o_reg_input_sel    = RIN_ALU;
      o_next_stage       = STG_FETCH;
      case (opcode)
         OPC_OP: begin
            o_alu_op      = is_m ? m_op(funct3) : base_op(funct3, alt, alt);
            o_wb_from_alu = 1'b1; // written back in fetch
         end
         OPC_OPIMM: begin
            o_s2_sel      = S2_IMM;
            o_alu_op      = base_op(funct3, 1'b0, funct7[5]); // no subi
            o_wb_from_alu = 1'b1;
         end
         OPC_LOAD: begin
            o_s2_sel     = S2_IMM; // rs1 + offset
            o_next_stage = STG_LOAD;
         end
         OPC_STORE: begin
            o_s2_sel     = S2_IMM;
            o_next_stage = STG_STORE;
         end
         OPC_JAL, OPC_JALR: begin
            o_write_reg        = 1'b1; // link
            o_s1_sel           = (opcode == OPC_JAL) ? S1_PC : S1_REGVAL1;
            o_s2_sel           = S2_IMM;
            o_next_pc_from_alu = 1'b1; // target from alu
         end
         OPC_BRANCH: o_next_stage = STG_BRANCH; // compare on regval1/regval2
         OPC_AUIPC: begin
            o_s1_sel      = S1_PC;
            o_s2_sel      = S2_IMM;
            o_wb_from_alu = 1'b1;
         end
         OPC_LUI: begin
            o_wb_from_imm   = 1'b1;
            o_reg_input_sel = RIN_IMM;
         end
         OPC_MISCMEM: o_next_stage = STG_FETCH; // fence is a nop here
         OPC_SYSTEM:  o_next_stage = STG_SYSTEM;
         default:     o_next_stage = STG_TRAP; // illegal opcode
      endcase
   end

   always_comb begin
      o_branch_mask = '0;
      if (opcode == OPC_BRANCH) begin
         case (funct3)
            F3_BEQ:  o_branch_mask[0] = 1'b1;
            F3_BNE:  o_branch_mask[1] = 1'b1;
            F3_BLT:  o_branch_mask[2] = 1'b1;
            F3_BGE:  o_branch_mask[3] = 1'b1;
            F3_BLTU: o_branch_mask[4] = 1'b1;
            F3_BGEU: o_branch_mask[5] = 1'b1;
            default: o_branch_mask    = '0; // 010/011 reserved
         endcase
      end
   end

endmodule

/* rvc_decoder.sv */
`timescale 1ns/100ps
module rvc_decoder
   import rv_decode_pkg::*;
(
   input  logic [XLEN-1:0]      i_instr, // low half only
   output logic [REG_IDX_W-1:0] o_rs1,
   output logic [REG_IDX_W-1:0] o_rs2,
   output logic [REG_IDX_W-1:0] o_rd,
   output logic [XLEN-1:0]      o_imm,
   output alu_op_e              o_alu_op,
   output alu_s1_sel_e          o_s1_sel,
   output alu_s2_sel_e          o_s2_sel,
   output logic                 o_wb_from_alu,
   output logic                 o_wb_from_imm,
   output logic                 o_next_pc_from_alu,
   output logic                 o_write_reg,
   output reg_input_sel_e       o_reg_input_sel,
   output logic [2:0]           o_funct3,
   output exec_stage_e          o_next_stage
);
   logic [1:0]           quad;
   logic [2:0]           c_funct3;
   logic [REG_IDX_W-1:0] rs1_full; // instr[11:7], rs1/rd
   logic [REG_IDX_W-1:0] rs2_full; // instr[6:2]

   assign quad     = i_instr[1:0];
   assign c_funct3 = i_instr[15:13];
   assign rs1_full = i_instr[11:7];
   assign rs2_full = i_instr[6:2];
   assign o_funct3 = FUNC_LW; // only word accesses exist in the subset

   always_comb begin
      o_rs1              = rs1_full;
      o_rs2              = rs2_full;
      o_rd               = rs1_full;
      o_imm              = '0;
      o_alu_op           = ALU_ADD;
      o_s1_sel           = S1_REGVAL1;
      o_s2_sel           = S2_REGVAL2;
      o_wb_from_alu      = 1'b0;
      o_wb_from_imm      = 1'b0; // never from imm in this subset
      o_next_pc_from_alu = 1'b0;
      o_write_reg        = 1'b0;
      o_reg_input_sel    = RIN_ALU;
      o_next_stage       = STG_DEAD; // unsupported unless matched below
      case (quad)
         C_Q0: begin
            o_rs1    = {2'b01, i_instr[9:7]}; // rs1' -> x8..x15
            o_rs2    = {2'b01, i_instr[4:2]};
            o_rd     = {2'b01, i_instr[4:2]};
            o_s2_sel = S2_IMM;
            o_imm    = {25'b0, i_instr[5], i_instr[12:10], i_instr[6], 2'b00}; // uimm*4
            case (c_funct3)
               C0_F3_LW:       o_next_stage = STG_LOAD;
               C0_F3_SW:       o_next_stage = STG_STORE;
               C0_F3_ADDI4SPN: o_imm        = '0; // not decoded, stays dead
               default:        o_next_stage = STG_DEAD; // fp / reserved
            endcase
         end
         C_Q1: o_next_stage = STG_DEAD; // c1 quadrant not supported
         C_Q2: begin
            case (c_funct3)
               C2_F3_SLLI: begin
                  o_s2_sel      = S2_IMM;
                  o_imm         = {27'b0, i_instr[6:2]}; // shamt
                  o_alu_op      = ALU_SLL;
                  o_wb_from_alu = 1'b1;
                  o_next_stage  = i_instr[12] ? STG_DEAD : STG_FETCH; // shamt[5] rv32 nse
               end
               C2_F3_LWSP: begin
                  o_rs1        = SP_REG;
                  o_s2_sel     = S2_IMM;
                  o_imm        = {24'b0, i_instr[3:2], i_instr[12], i_instr[6:4], 2'b00};
                  o_next_stage = (rs1_full == '0) ? STG_DEAD : STG_LOAD; // rd 0 reserved
               end
               C2_F3_SWSP: begin
                  o_rs1        = SP_REG;
                  o_s2_sel     = S2_IMM;
                  o_imm        = {24'b0, i_instr[8:7], i_instr[12:9], 2'b00};
                  o_next_stage = STG_STORE;
               end
               C2_F3_JR: begin
                  if (i_instr[12]) begin
                     if (rs1_full != '0 && rs2_full != '0) begin // c.add
                        o_wb_from_alu = 1'b1;
                        o_next_stage  = STG_FETCH;
                     end else if (rs1_full != '0) begin // c.jalr
                        o_write_reg        = 1'b1;
                        o_rd               = RA_REG;
                        o_next_pc_from_alu = 1'b1;
                        o_next_stage       = STG_FETCH;
                     end // else c.ebreak, left dead
                  end else if (rs2_full != '0) begin // c.mv as x0 + rs2
                     o_rs1         = '0;
                     o_wb_from_alu = 1'b1;
                     o_next_stage  = STG_FETCH;
                  end else if (rs1_full != '0) begin // c.jr
                     o_next_pc_from_alu = 1'b1;
                     o_next_stage       = STG_FETCH;
                  end // c.jr with rs1 0 is reserved
               end
               default: o_next_stage = STG_DEAD; // fp sp loads/stores
            endcase
         end
         default: o_next_stage = STG_DEAD; // length test lives in the stage reg
      endcase
   end

endmodule

/* decode_stage_reg.sv */
`timescale 1ns/100ps
module decode_stage_reg
   import rv_decode_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_en,             // one decode per strobe
   input  logic [XLEN-1:0]      i_instr,          // only [1:0] looked at
   input  logic [REG_IDX_W-1:0] i_f_rs1,          // i_f_* from rv32 decoder
   input  logic [REG_IDX_W-1:0] i_f_rs2,
   input  logic [REG_IDX_W-1:0] i_f_rd,
   input  logic [XLEN-1:0]      i_f_imm,
   input  alu_op_e              i_f_alu_op,
   input  alu_s1_sel_e          i_f_s1_sel,
   input  alu_s2_sel_e          i_f_s2_sel,
   input  logic                 i_f_wb_from_alu,
   input  logic                 i_f_wb_from_imm,
   input  logic                 i_f_next_pc_from_alu,
   input  logic                 i_f_write_reg,
   input  reg_input_sel_e       i_f_reg_input_sel,
   input  logic [2:0]           i_f_funct3,
   input  exec_stage_e          i_f_next_stage,
   input  logic [5:0]           i_f_branch_mask,
   input  logic [REG_IDX_W-1:0] i_c_rs1,          // i_c_* from rvc decoder
   input  logic [REG_IDX_W-1:0] i_c_rs2,
   input  logic [REG_IDX_W-1:0] i_c_rd,
   input  logic [XLEN-1:0]      i_c_imm,
   input  alu_op_e              i_c_alu_op,
   input  alu_s1_sel_e          i_c_s1_sel,
   input  alu_s2_sel_e          i_c_s2_sel,
   input  logic                 i_c_wb_from_alu,
   input  logic                 i_c_wb_from_imm,
   input  logic                 i_c_next_pc_from_alu,
   input  logic                 i_c_write_reg,
   input  reg_input_sel_e       i_c_reg_input_sel,
   input  logic [2:0]           i_c_funct3,
   input  exec_stage_e          i_c_next_stage,
   output logic                 o_valid,
   output logic [REG_IDX_W-1:0] o_rs1,
   output logic [REG_IDX_W-1:0] o_rs2,
   output logic [REG_IDX_W-1:0] o_rd,
   output logic [XLEN-1:0]      o_imm,
   output alu_op_e              o_alu_op,
   output alu_s1_sel_e          o_s1_sel,
   output alu_s2_sel_e          o_s2_sel,
   output logic                 o_wb_from_alu,
   output logic                 o_wb_from_imm,
   output logic                 o_next_pc_from_alu,
   output logic                 o_write_reg,
   output reg_input_sel_e       o_reg_input_sel,
   output logic [2:0]           o_funct3,
   output exec_stage_e          o_next_stage,
   output logic [5:0]           o_branch_mask
);
   logic is_32;

   assign is_32 = (i_instr[1:0] == C_Q32); // full-length word

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid            <= 1'b0;
         o_rs1              <= '0;
         o_rs2              <= '0;
         o_rd               <= '0;
         o_imm              <= '0;
         o_alu_op           <= ALU_ADD;
         o_s1_sel           <= S1_REGVAL1;
         o_s2_sel           <= S2_REGVAL2;
         o_wb_from_alu      <= 1'b0;
         o_wb_from_imm      <= 1'b0;
         o_next_pc_from_alu <= 1'b0;
         o_write_reg        <= 1'b0;
         o_reg_input_sel    <= RIN_ALU;
         o_funct3           <= '0;
         o_next_stage       <= STG_DEAD; // nothing to execute yet
         o_branch_mask      <= '0;
      end else begin
         o_valid <= i_en; // single-cycle pulse per strobe
         if (i_en) begin // hold last result otherwise
            o_rs1              <= is_32 ? i_f_rs1 : i_c_rs1;
            o_rs2              <= is_32 ? i_f_rs2 : i_c_rs2;
            o_rd               <= is_32 ? i_f_rd : i_c_rd;
            o_imm              <= is_32 ? i_f_imm : i_c_imm;
            o_alu_op           <= is_32 ? i_f_alu_op : i_c_alu_op;
            o_s1_sel           <= is_32 ? i_f_s1_sel : i_c_s1_sel;
            o_s2_sel           <= is_32 ? i_f_s2_sel : i_c_s2_sel;
            o_wb_from_alu      <= is_32 ? i_f_wb_from_alu : i_c_wb_from_alu;
            o_wb_from_imm      <= is_32 ? i_f_wb_from_imm : i_c_wb_from_imm;
            o_next_pc_from_alu <= is_32 ? i_f_next_pc_from_alu : i_c_next_pc_from_alu;
            o_write_reg        <= is_32 ? i_f_write_reg : i_c_write_reg;
            o_reg_input_sel    <= is_32 ? i_f_reg_input_sel : i_c_reg_input_sel;
            o_funct3           <= is_32 ? i_f_funct3 : i_c_funct3;
            o_next_stage       <= is_32 ? i_f_next_stage : i_c_next_stage;
            o_branch_mask      <= is_32 ? i_f_branch_mask : 6'b0; // no rvc branches
         end
      end
   end

   // loads write through the load path, never from the alu
   a_load_no_alu_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_valid && o_next_stage == STG_LOAD) |-> !(o_write_reg && o_wb_from_alu));

endmodule

/* instr_decoder.sv */
`timescale 1ns/100ps
module instr_decoder
   import rv_decode_pkg::*;
#(
   parameter bit P_EXT_M = 1'b1 // m extension decode
) (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_en,
   input  logic [XLEN-1:0]      i_instr,
   output logic                 o_valid,
   output logic [REG_IDX_W-1:0] o_rs1,
   output logic [REG_IDX_W-1:0] o_rs2,
   output logic [REG_IDX_W-1:0] o_rd,
   output logic [XLEN-1:0]      o_imm,
   output alu_op_e              o_alu_op,
   output alu_s1_sel_e          o_s1_sel,
   output alu_s2_sel_e          o_s2_sel,
   output logic                 o_wb_from_alu,
   output logic                 o_wb_from_imm,
   output logic                 o_next_pc_from_alu,
   output logic                 o_write_reg,
   output reg_input_sel_e       o_reg_input_sel,
   output logic [2:0]           o_funct3,
   output exec_stage_e          o_next_stage,
   output logic [5:0]           o_branch_mask
);
   logic [REG_IDX_W-1:0] f_rs1, f_rs2, f_rd, c_rs1, c_rs2, c_rd; // f_ 32-bit, c_ rvc
   logic [XLEN-1:0]      f_imm, c_imm;
   alu_op_e              f_alu_op, c_alu_op;
   alu_s1_sel_e          f_s1_sel, c_s1_sel;
   alu_s2_sel_e          f_s2_sel, c_s2_sel;
   logic                 f_wb_alu, c_wb_alu, f_wb_imm, c_wb_imm;
   logic                 f_pc_alu, c_pc_alu, f_write_reg, c_write_reg;
   reg_input_sel_e       f_rin_sel, c_rin_sel;
   logic [2:0]           f_funct3, c_funct3;
   exec_stage_e          f_stage, c_stage;
   logic [5:0]           f_mask;

   rv32_decoder #(.P_EXT_M(P_EXT_M)) u_rv32 (
      .i_instr(i_instr), .o_rs1(f_rs1), .o_rs2(f_rs2), .o_rd(f_rd), .o_imm(f_imm),
      .o_alu_op(f_alu_op), .o_s1_sel(f_s1_sel), .o_s2_sel(f_s2_sel),
      .o_wb_from_alu(f_wb_alu), .o_wb_from_imm(f_wb_imm), .o_next_pc_from_alu(f_pc_alu),
      .o_write_reg(f_write_reg), .o_reg_input_sel(f_rin_sel), .o_funct3(f_funct3),
      .o_next_stage(f_stage), .o_branch_mask(f_mask)
   );

   rvc_decoder u_rvc (
      .i_instr(i_instr), .o_rs1(c_rs1), .o_rs2(c_rs2), .o_rd(c_rd), .o_imm(c_imm),
      .o_alu_op(c_alu_op), .o_s1_sel(c_s1_sel), .o_s2_sel(c_s2_sel),
      .o_wb_from_alu(c_wb_alu), .o_wb_from_imm(c_wb_imm), .o_next_pc_from_alu(c_pc_alu),
      .o_write_reg(c_write_reg), .o_reg_input_sel(c_rin_sel), .o_funct3(c_funct3),
      .o_next_stage(c_stage)
   );

   decode_stage_reg u_stage (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en(i_en), .i_instr(i_instr),
      .i_f_rs1(f_rs1), .i_f_rs2(f_rs2), .i_f_rd(f_rd), .i_f_imm(f_imm),
      .i_f_alu_op(f_alu_op), .i_f_s1_sel(f_s1_sel), .i_f_s2_sel(f_s2_sel),
      .i_f_wb_from_alu(f_wb_alu), .i_f_wb_from_imm(f_wb_imm),
      .i_f_next_pc_from_alu(f_pc_alu), .i_f_write_reg(f_write_reg),
      .i_f_reg_input_sel(f_rin_sel), .i_f_funct3(f_funct3), .i_f_next_stage(f_stage),
      .i_f_branch_mask(f_mask),
      .i_c_rs1(c_rs1), .i_c_rs2(c_rs2), .i_c_rd(c_rd), .i_c_imm(c_imm),
      .i_c_alu_op(c_alu_op), .i_c_s1_sel(c_s1_sel), .i_c_s2_sel(c_s2_sel),
      .i_c_wb_from_alu(c_wb_alu), .i_c_wb_from_imm(c_wb_imm),
      .i_c_next_pc_from_alu(c_pc_alu), .i_c_write_reg(c_write_reg),
      .i_c_reg_input_sel(c_rin_sel), .i_c_funct3(c_funct3), .i_c_next_stage(c_stage),
      .o_valid(o_valid), .o_rs1(o_rs1), .o_rs2(o_rs2), .o_rd(o_rd), .o_imm(o_imm),
      .o_alu_op(o_alu_op), .o_s1_sel(o_s1_sel), .o_s2_sel(o_s2_sel),
      .o_wb_from_alu(o_wb_from_alu), .o_wb_from_imm(o_wb_from_imm),
      .o_next_pc_from_alu(o_next_pc_from_alu), .o_write_reg(o_write_reg),
      .o_reg_input_sel(o_reg_input_sel), .o_funct3(o_funct3),
      .o_next_stage(o_next_stage), .o_branch_mask(o_branch_mask)
   );

endmodule

/* tb_vectors.svh */
// columns: instr, rs1, rs2, rd, imm, alu_op, s1_sel, s2_sel,
// flags {wb_from_alu, wb_from_imm, next_pc_from_alu, write_reg}, next_stage, branch mask
task automatic load_table();
   // op, register-register, x3 = x1 op x2, imm is the i-field
   add_row('h002081b3, 1, 2, 3, 'h2, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h402081b3, 1, 2, 3, 'h402, ALU_SUB, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h4020d1b3, 1, 2, 3, 'h402, ALU_SRA, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h022081b3, 1, 2, 3, 'h22, ALU_MUL, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h022091b3, 1, 2, 3, 'h22, ALU_MULH, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h0220a1b3, 1, 2, 3, 'h22, ALU_MULHSU, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h0220b1b3, 1, 2, 3, 'h22, ALU_MULHU, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h0220c1b3, 1, 2, 3, 'h22, ALU_DIV, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h0220d1b3, 1, 2, 3, 'h22, ALU_DIVU, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h0220e1b3, 1, 2, 3, 'h22, ALU_REM, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h0220f1b3, 1, 2, 3, 'h22, ALU_REMU, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   // op-imm: addi x5,x6,-1 and srai x5,x6,3
   add_row('hfff30293, 6, 31, 5, -1, ALU_ADD, S1_REGVAL1, S2_IMM, 'b1000, STG_FETCH, 0);
   add_row('h40335293, 6, 3, 5, 'h403, ALU_SRA, S1_REGVAL1, S2_IMM, 'b1000, STG_FETCH, 0);
   // lw x7,8(x9) and sw x10,-4(x11)
   add_row('h0084a383, 9, 8, 7, 8, ALU_ADD, S1_REGVAL1, S2_IMM, 'b0000, STG_LOAD, 0);
   add_row('hfea5ae23, 11, 10, 28, -4, ALU_ADD, S1_REGVAL1, S2_IMM, 'b0000, STG_STORE, 0);
   // branches on x1,x2: beq -8, the rest +16
   add_row('hfe208ce3, 1, 2, 25, -8, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_BRANCH, 'h01);
   add_row('h00209863, 1, 2, 16, 16, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_BRANCH, 'h02);
   add_row('h0020c863, 1, 2, 16, 16, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_BRANCH, 'h04);
   add_row('h0020d863, 1, 2, 16, 16, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_BRANCH, 'h08);
   add_row('h0020e863, 1, 2, 16, 16, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_BRANCH, 'h10);
   add_row('h0020f863, 1, 2, 16, 16, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_BRANCH, 'h20);
   // lui, jal, jalr, ecall, illegal opcode
   add_row('h123451b7, 8, 3, 3, 'h12345000, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0100, STG_FETCH, 0);
   add_row('h001000ef, 0, 1, 1, 'h800, ALU_ADD, S1_PC, S2_IMM, 'b0011, STG_FETCH, 0);
   add_row('h004280e7, 5, 4, 1, 4, ALU_ADD, S1_REGVAL1, S2_IMM, 'b0011, STG_FETCH, 0);
   add_row('h00000073, 0, 0, 0, 0, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_SYSTEM, 0);
   add_row('h0000007f, 0, 0, 0, 0, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0000, STG_TRAP, 0);
   // compressed: c.lw, c.sw, c.slli, c.lwsp, c.swsp
   add_row('h4544, 10, 9, 9, 12, ALU_ADD, S1_REGVAL1, S2_IMM, 'b0000, STG_LOAD, 0);
   add_row('hc04c, 8, 11, 11, 4, ALU_ADD, S1_REGVAL1, S2_IMM, 'b0000, STG_STORE, 0);
   add_row('h029e, 5, 7, 5, 7, ALU_SLL, S1_REGVAL1, S2_IMM, 'b1000, STG_FETCH, 0);
   add_row('h4322, 2, 8, 6, 8, ALU_ADD, S1_REGVAL1, S2_IMM, 'b0000, STG_LOAD, 0);
   add_row('hc81e, 2, 7, 16, 16, ALU_ADD, S1_REGVAL1, S2_IMM, 'b0000, STG_STORE, 0);
   // c.jr x5, c.mv x5,x6, c.jalr x5, c.add x5,x6
   add_row('h8282, 5, 0, 5, 0, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0010, STG_FETCH, 0);
   add_row('h829a, 0, 6, 5, 0, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   add_row('h9282, 5, 0, 1, 0, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b0011, STG_FETCH, 0);
   add_row('h929a, 5, 6, 5, 0, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 'b1000, STG_FETCH, 0);
   // dead: ebreak, addi4spn, lwsp rd 0, jr rs1 0, slli shamt5, two c1 words
   add_dead('h9002);
   add_dead('h0040);
   add_dead('h4022);
   add_dead('h8002);
   add_dead('h129e);
   add_dead('h0001);
   add_dead('h4505);
endtask

/* tb_instr_decoder.sv */
`timescale 1ns/100ps
module tb_instr_decoder;
   import rv_decode_pkg::*;

   localparam int CLK_PERIOD = 40;

   typedef struct {
      int          instr;
      int          rs1;
      int          rs2;
      int          rd;
      int          imm;
      alu_op_e     op;
      alu_s1_sel_e s1;
      alu_s2_sel_e s2;
      int          flags; // wb_alu, wb_imm, pc_alu, write_reg
      exec_stage_e stage;
      int          mask;
      bit          full;  // 0: only stage, mask, funct3 checked
   } row_t;

   logic i_clk = 1'b0;
   logic i_rst_n = 1'b0;
   logic i_en = 1'b0;
   logic [XLEN-1:0] i_instr = '0;
   logic o_valid, o_wb_from_alu, o_wb_from_imm, o_next_pc_from_alu, o_write_reg;
   logic [REG_IDX_W-1:0] o_rs1, o_rs2, o_rd;
   logic [XLEN-1:0] o_imm;
   alu_op_e o_alu_op;
   alu_s1_sel_e o_s1_sel;
   alu_s2_sel_e o_s2_sel;
   reg_input_sel_e o_reg_input_sel;
   logic [2:0] o_funct3;
   exec_stage_e o_next_stage;
   logic [5:0] o_branch_mask;

   row_t rows[$];
   int   pending[$]; // row indices launched, not yet seen
   int   mismatches = 0;
   int   other_errs = 0;
   logic en_seen = 1'b0;

   instr_decoder #(.P_EXT_M(1'b1)) u_dut (.*);

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   always @(posedge i_clk) en_seen <= i_en; // strobe taken at this edge

   task automatic add_row(input int instr, input int rs1, input int rs2, input int rd,
         input int imm, input alu_op_e op, input alu_s1_sel_e s1, input alu_s2_sel_e s2,
         input int flags, input exec_stage_e stage, input int mask);
      row_t r;
      r = '{instr, rs1, rs2, rd, imm, op, s1, s2, flags, stage, mask, 1'b1};
      rows.push_back(r);
   endtask

   task automatic add_dead(input int instr);
      row_t r;
      r = '{instr, 0, 0, 0, 0, ALU_ADD, S1_REGVAL1, S2_REGVAL2, 0, STG_DEAD, 0, 1'b0};
      rows.push_back(r);
   endtask

   `include "tb_vectors.svh"

   task automatic check_field(input string name, input int exp, input int act);
      if (exp != act) begin
         mismatches++;
         $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      end
   endtask

   task automatic check_row(input row_t r);
      int f3;
      f3 = (r.instr[1:0] == 2'b11) ? int'(r.instr[14:12]) : int'(FUNC_LW); // rvc: word
      check_field("o_next_stage", int'(r.stage), int'(o_next_stage));
      check_field("o_branch_mask", r.mask, int'(o_branch_mask));
      check_field("o_funct3", f3, int'(o_funct3));
      if (r.full) begin
         check_field("o_rs1", r.rs1, int'(o_rs1));
         check_field("o_rs2", r.rs2, int'(o_rs2));
         check_field("o_rd", r.rd, int'(o_rd));
         check_field("o_imm", r.imm, int'(o_imm));
         check_field("o_alu_op", int'(r.op), int'(o_alu_op));
         check_field("o_s1_sel", int'(r.s1), int'(o_s1_sel));
         check_field("o_s2_sel", int'(r.s2), int'(o_s2_sel));
         check_field("o_wb_from_alu", int'(r.flags[3]), int'(o_wb_from_alu));
         check_field("o_wb_from_imm", int'(r.flags[2]), int'(o_wb_from_imm));
         check_field("o_next_pc_from_alu", int'(r.flags[1]), int'(o_next_pc_from_alu));
         check_field("o_write_reg", int'(r.flags[0]), int'(o_write_reg));
         check_field("o_reg_input_sel", r.flags[2] ? int'(RIN_IMM) : int'(RIN_ALU),
                     int'(o_reg_input_sel)); // imm writeback selects the imm source
      end
   endtask

   // outputs are stable at the falling edge
   initial begin
      wait (i_rst_n === 1'b1);
      forever begin
         @(negedge i_clk);
         if (o_valid !== en_seen) begin
            other_errs++;
            $display("t=%0t o_valid was %b but the enable one edge earlier was %b",
                     $time, o_valid, en_seen);
         end
         if (o_valid === 1'b1) begin
            if (pending.size() == 0) begin
               other_errs++;
               $display("t=%0t o_valid rose with no instruction in flight", $time);
            end else begin
               check_row(rows[pending.pop_front()]);
            end
         end
      end
   end

   initial begin
      int gap;
      int limit;
      void'($urandom(32'h2ea146e1));
      load_table();
      limit = (rows.size() * 6 + 2 + 4) * CLK_PERIOD; // ns
      fork
         begin
            #(limit);
            $display("watchdog expired after %0d ns with %0d results outstanding",
                     limit, pending.size());
            $display("Some tests failed");
            $finish;
         end
      join_none
      repeat (2) @(posedge i_clk);
      #2 i_rst_n = 1'b1;
      @(negedge i_clk);
      check_field("o_valid", 0, int'(o_valid));
      check_field("o_next_stage", int'(STG_DEAD), int'(o_next_stage));
      check_field("o_write_reg", 0, int'(o_write_reg));
      check_field("o_branch_mask", 0, int'(o_branch_mask));
      for (int k = 0; k < rows.size(); k++) begin
         gap = $urandom_range(3, 0); // 0 gives back-to-back strobes
         repeat (gap) begin
            @(posedge i_clk);
            #2 i_en = 1'b0;
         end
         @(posedge i_clk);
         #2;
         i_en = 1'b1;
         i_instr = rows[k].instr;
         pending.push_back(k);
      end
      @(posedge i_clk);
      #2 i_en = 1'b0;
      while (pending.size() != 0) @(negedge i_clk);
      @(negedge i_clk); // valid must have dropped again
      #1; // monitor finishes this edge first
      $display("summary: %0d rows, %0d value mismatches, %0d other errors",
               rows.size(), mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+.
rv_decode_pkg.sv
rv32_decoder.sv
rvc_decoder.sv
decode_stage_reg.sv
instr_decoder.sv
tb_instr_decoder.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_instr_decoder
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FLIST)) tb_vectors.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(OBJ_DIR)/V%: $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $* --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
